// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pcie_queue
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bar_read_path.sv
`timescale 1ns/1ps
`default_nettype none
`include "pcie_queue_cfg.svh"

module bar_read_path (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    input  logic                       pcie_read,
    input  pcie_queue_pkg::bar_addr_t  pcie_address,

    output pcie_queue_pkg::core_idx_t  win_core,
    input  logic [127:0]               win_data,

    output logic                       frb_read,
    output pcie_queue_pkg::line_addr_t frb_address,
    input  pcie_queue_pkg::bar_line_t  frb_readdata,
    input  logic                       frb_readvalid,

    output pcie_queue_pkg::bar_line_t  pcie_readdata,
    output logic                       pcie_readdatavalid
);

    pcie_queue_pkg::line_addr_t line_addr;
    logic                       reg_region;
    logic                       reg_region_r1;
    logic                       reg_region_r2;
    logic                       read_r1;
    logic                       read_r2;
    pcie_queue_pkg::core_idx_t  core_r1;
    pcie_queue_pkg::core_idx_t  core_r2;
    logic                       reg_resp;

    assign line_addr  = pcie_address[`PQ_ADDR_WIDTH-1:6];
    assign reg_region = line_addr < pcie_queue_pkg::line_addr_t'(`PQ_BRAM_OFFSET);

    // BRAM lines go straight out with the offset removed
    assign frb_read    = pcie_read && !reg_region;
    assign frb_address = line_addr - pcie_queue_pkg::line_addr_t'(`PQ_BRAM_OFFSET);

    // two cycle delay on the register side
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            reg_region_r1 <= 1'b0;
            reg_region_r2 <= 1'b0;
            read_r1       <= 1'b0;
            read_r2       <= 1'b0;
        end else begin
            reg_region_r1 <= reg_region;
            reg_region_r2 <= reg_region_r1;
            read_r1       <= pcie_read;
            read_r2       <= read_r1;
        end
    end

    // core index travels with the read
    always_ff @(posedge pcie_clk) begin
        core_r1 <= pcie_address[`PQ_WINDOW_SHIFT +: `PQ_CORE_BITS];
        core_r2 <= core_r1;
    end

    assign win_core = core_r2;
    assign reg_resp = read_r2 && reg_region_r2;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            pcie_readdatavalid <= 1'b0;
        end else begin
            pcie_readdatavalid <= reg_resp || frb_readvalid;
        end
    end

    // register window zero-extended to a full line
    always_ff @(posedge pcie_clk) begin
        if (reg_resp) begin
            pcie_readdata <= {384'b0, win_data};
        end else if (frb_readvalid) begin
            pcie_readdata <= frb_readdata;
        end
    end

endmodule

`default_nettype wire

// File: core_ring_pointer.sv
`timescale 1ns/1ps
`default_nettype none

module core_ring_pointer (
    input  logic                      pcie_clk,
    input  logic                      pcie_reset_n,
    input  logic                      dma_done,
    input  logic [2:0]                total_core,
    output pcie_queue_pkg::core_idx_t core_id
);

    logic last_core;

    // wrap at the configured core count
    assign last_core = (3'(core_id) == total_core - 3'd1);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            core_id <= '0;
        end else if (dma_done) begin
            if (last_core) begin
                core_id <= '0;
            end else begin
                core_id <= core_id + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: pcie_queue_cfg.svh
`ifndef PCIE_QUEUE_CFG_SVH
`define PCIE_QUEUE_CFG_SVH

// number of DMA cores and bits of a core index
`define PQ_NUM_CORES 4
`define PQ_CORE_BITS 2

// BAR 0 byte address width
`define PQ_ADDR_WIDTH 16

// core index starts at this address bit, 4 KB window per core
`define PQ_WINDOW_SHIFT 12

// first 64-byte line served by the ring buffer BRAM
`define PQ_BRAM_OFFSET 256

// ring head and tail pointer width
`define PQ_RB_AWIDTH 16

`endif

// File: pcie_queue_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "pcie_queue_cfg.svh"

module pcie_queue_checker (
    input logic                      pcie_clk,
    input logic                      pcie_reset_n,
    input logic                      pcie_read,
    input pcie_queue_pkg::bar_addr_t pcie_address,
    input logic                      pcie_readdatavalid,
    input logic                      frb_read,
    input logic                      dma_done,
    input pcie_queue_pkg::ring_ptr_t new_tail,
    input logic [2:0]                total_core,
    input pcie_queue_pkg::ring_ptr_t f2c_tail
);

    logic                      reg_line;
    pcie_queue_pkg::core_idx_t done_core;
    pcie_queue_pkg::ring_ptr_t last_tail [`PQ_NUM_CORES];
    pcie_queue_pkg::ring_ptr_t sel_tail;
    int                        assert_fails;

    initial begin
        assert_fails = 0;
    end

    assign reg_line = pcie_address[`PQ_ADDR_WIDTH-1:6] < `PQ_BRAM_OFFSET;

    // tails by done pulse, cores taken round robin over total_core
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int i = 0; i < `PQ_NUM_CORES; i++) begin
                last_tail[i] <= '0;
            end
            done_core <= '0;
            sel_tail  <= '0;
        end else begin
            sel_tail <= last_tail[done_core];
            if (dma_done) begin
                last_tail[done_core] <= new_tail;
                done_core <= pcie_queue_pkg::core_idx_t'(
                    (int'(done_core) + 1) % int'(total_core));
            end
        end
    end

    reg_read_latency: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        pcie_read && reg_line |-> ##3 pcie_readdatavalid)
        else begin
            $error("register read without valid three cycles later");
            assert_fails++;
        end

    no_bram_for_regs: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        frb_read |-> !reg_line)
        else begin
            $error("frb_read raised for a register address");
            assert_fails++;
        end

    tail_follows_done: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        f2c_tail == sel_tail)
        else begin
            $error("f2c_tail differs from last written tail");
            assert_fails++;
        end

endmodule

bind pcie_queue_top pcie_queue_checker chk (
    .pcie_clk           (pcie_clk),
    .pcie_reset_n       (pcie_reset_n),
    .pcie_read          (pcie_read),
    .pcie_address       (pcie_address),
    .pcie_readdatavalid (pcie_readdatavalid),
    .frb_read           (frb_read),
    .dma_done           (dma_done),
    .new_tail           (new_tail),
    .total_core         (total_core),
    .f2c_tail           (f2c_tail)
);

`default_nettype wire

// File: pcie_queue_pkg.sv
`default_nettype none
`include "pcie_queue_cfg.svh"

package pcie_queue_pkg;

    // core index
    typedef logic [`PQ_CORE_BITS-1:0] core_idx_t;

    // ring head or tail pointer
    typedef logic [`PQ_RB_AWIDTH-1:0] ring_ptr_t;

    // kernel memory address of a ring
    typedef logic [63:0] kmem_addr_t;

    // one BAR data line and its byte enables
    typedef logic [511:0] bar_line_t;
    typedef logic [63:0] bar_be_t;

    // byte address and 64-byte line address
    typedef logic [`PQ_ADDR_WIDTH-1:0] bar_addr_t;
    typedef logic [`PQ_ADDR_WIDTH-7:0] line_addr_t;

endpackage

`default_nettype wire

// File: pcie_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_queue_top (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    // BAR 0
    input  logic                       pcie_read,
    input  logic                       pcie_write,
    input  pcie_queue_pkg::bar_addr_t  pcie_address,
    input  pcie_queue_pkg::bar_line_t  pcie_writedata,
    input  pcie_queue_pkg::bar_be_t    pcie_byteenable,
    output pcie_queue_pkg::bar_line_t  pcie_readdata,
    output logic                       pcie_readdatavalid,

    // from the f2c engine
    input  logic                       dma_done,
    input  pcie_queue_pkg::ring_ptr_t  new_tail,
    input  logic [2:0]                 total_core,

    // ring buffer BRAM read port
    output logic                       frb_read,
    output pcie_queue_pkg::line_addr_t frb_address,
    input  pcie_queue_pkg::bar_line_t  frb_readdata,
    input  logic                       frb_readvalid,

    // selected queue
    output pcie_queue_pkg::ring_ptr_t  f2c_head,
    output pcie_queue_pkg::ring_ptr_t  f2c_tail,
    output pcie_queue_pkg::kmem_addr_t f2c_kmem_addr
);

    pcie_queue_pkg::core_idx_t core_id;
    pcie_queue_pkg::core_idx_t win_core;
    logic [127:0]              win_data;

    core_ring_pointer u_core_ring_pointer (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .dma_done     (dma_done),
        .total_core   (total_core),
        .core_id      (core_id)
    );

    queue_reg_file u_queue_reg_file (
        .pcie_clk        (pcie_clk),
        .pcie_reset_n    (pcie_reset_n),
        .pcie_write      (pcie_write),
        .pcie_address    (pcie_address),
        .pcie_writedata  (pcie_writedata),
        .pcie_byteenable (pcie_byteenable),
        .dma_done        (dma_done),
        .new_tail        (new_tail),
        .core_id         (core_id),
        .win_core        (win_core),
        .win_data        (win_data),
        .f2c_head        (f2c_head),
        .f2c_tail        (f2c_tail),
        .f2c_kmem_addr   (f2c_kmem_addr)
    );

    bar_read_path u_bar_read_path (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .pcie_read          (pcie_read),
        .pcie_address       (pcie_address),
        .win_core           (win_core),
        .win_data           (win_data),
        .frb_read           (frb_read),
        .frb_address        (frb_address),
        .frb_readdata       (frb_readdata),
        .frb_readvalid      (frb_readvalid),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid)
    );

endmodule

`default_nettype wire

// File: queue_reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "pcie_queue_cfg.svh"

module queue_reg_file (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,

    input  logic                       pcie_write,
    input  pcie_queue_pkg::bar_addr_t  pcie_address,
    input  pcie_queue_pkg::bar_line_t  pcie_writedata,
    input  pcie_queue_pkg::bar_be_t    pcie_byteenable,

    input  logic                       dma_done,
    input  pcie_queue_pkg::ring_ptr_t  new_tail,
    input  pcie_queue_pkg::core_idx_t  core_id,

    input  pcie_queue_pkg::core_idx_t  win_core,
    output logic [127:0]               win_data,

    output pcie_queue_pkg::ring_ptr_t  f2c_head,
    output pcie_queue_pkg::ring_ptr_t  f2c_tail,
    output pcie_queue_pkg::kmem_addr_t f2c_kmem_addr
);

    localparam int PAD_W = 32 - `PQ_RB_AWIDTH;

    pcie_queue_pkg::ring_ptr_t tail [`PQ_NUM_CORES];
    pcie_queue_pkg::ring_ptr_t head [`PQ_NUM_CORES];
    logic [31:0]               kmem_low [`PQ_NUM_CORES];
    logic [31:0]               kmem_high [`PQ_NUM_CORES];

    pcie_queue_pkg::core_idx_t wr_core;
    logic                      wr_reg_region;
    logic                      head_wr;
    logic                      kmem_low_wr;
    logic                      kmem_high_wr;

    // core window decode, BRAM lines never touch the registers
    assign wr_core       = pcie_address[`PQ_WINDOW_SHIFT +: `PQ_CORE_BITS];
    assign wr_reg_region = pcie_address[`PQ_ADDR_WIDTH-1:6] <
                           pcie_queue_pkg::line_addr_t'(`PQ_BRAM_OFFSET);

    // dword 0 is the tail and stays FPGA-owned
    assign head_wr      = pcie_write && wr_reg_region && (&pcie_byteenable[7:4]);
    assign kmem_low_wr  = pcie_write && wr_reg_region && (&pcie_byteenable[11:8]);
    assign kmem_high_wr = pcie_write && wr_reg_region && (&pcie_byteenable[15:12]);

    // host-written registers
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int i = 0; i < `PQ_NUM_CORES; i++) begin
                head[i]      <= '0;
                kmem_low[i]  <= '0;
                kmem_high[i] <= '0;
            end
        end else begin
            if (head_wr) begin
                head[wr_core] <= pcie_writedata[32 +: `PQ_RB_AWIDTH];
            end
            if (kmem_low_wr) begin
                kmem_low[wr_core] <= pcie_writedata[95:64];
            end
            if (kmem_high_wr) begin
                kmem_high[wr_core] <= pcie_writedata[127:96];
            end
        end
    end

    // tail of the current core on each DMA completion
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int i = 0; i < `PQ_NUM_CORES; i++) begin
                tail[i] <= '0;
            end
        end else if (dma_done) begin
            tail[core_id] <= new_tail;
        end
    end

    // queue handed to the f2c engine
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            f2c_head      <= '0;
            f2c_tail      <= '0;
            f2c_kmem_addr <= '0;
        end else begin
            f2c_head      <= head[core_id];
            f2c_tail      <= tail[core_id];
            f2c_kmem_addr <= {kmem_high[core_id], kmem_low[core_id]};
        end
    end

    // tail, head, kmem low, kmem high from dword 0 up
    assign win_data = {
        kmem_high[win_core],
        kmem_low[win_core],
        {PAD_W{1'b0}}, head[win_core],
        {PAD_W{1'b0}}, tail[win_core]
    };

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
pcie_queue_pkg.sv
core_ring_pointer.sv
queue_reg_file.sv
bar_read_path.sv
pcie_queue_top.sv
tb_clock_gen.sv
tb_scoreboard.sv
pcie_queue_checker.sv
tb_pcie_queue.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic pcie_clk,
    output logic pcie_reset_n
);

    initial begin
        pcie_clk = 1'b0;
        forever #20 pcie_clk = ~pcie_clk;
    end

    // low through two rising edges
    initial begin
        pcie_reset_n = 1'b0;
        repeat (2) @(posedge pcie_clk);
        #1 pcie_reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_pcie_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_queue;

    typedef enum int {OP_WR, OP_RD, OP_BRD, OP_DONE, OP_IDLE} op_e;

    typedef struct {
        op_e          op;
        logic [15:0]  addr;
        logic [127:0] data;
        logic [15:0]  be;
        logic [127:0] exp;
    } entry_t;

    logic                       pcie_clk;
    logic                       pcie_reset_n;
    logic                       pcie_read;
    logic                       pcie_write;
    logic                       dma_done;
    logic                       frb_readvalid;
    pcie_queue_pkg::bar_addr_t  pcie_address;
    pcie_queue_pkg::bar_line_t  pcie_writedata;
    pcie_queue_pkg::bar_line_t  pcie_readdata;
    pcie_queue_pkg::bar_line_t  frb_readdata;
    pcie_queue_pkg::bar_be_t    pcie_byteenable;
    logic                       pcie_readdatavalid;
    logic                       frb_read;
    pcie_queue_pkg::ring_ptr_t  new_tail;
    pcie_queue_pkg::ring_ptr_t  f2c_head;
    pcie_queue_pkg::ring_ptr_t  f2c_tail;
    pcie_queue_pkg::kmem_addr_t f2c_kmem_addr;
    pcie_queue_pkg::line_addr_t frb_address;
    logic [2:0]                 total_core;
    logic [127:0]               table_exp;
    int                         error_count;
    int                         pending;
    int                         timeouts;
    integer                     seed;
    entry_t                     tbl [$];
    logic                       pend1;
    logic                       pend2;
    pcie_queue_pkg::line_addr_t addr1;
    pcie_queue_pkg::line_addr_t addr2;

    tb_clock_gen clk_gen (.pcie_clk(pcie_clk), .pcie_reset_n(pcie_reset_n));

    pcie_queue_top dut (.*);

    tb_scoreboard sb (.*);

    // BRAM answers two cycles after frb_read
    always @(posedge pcie_clk) begin
        pend2 = pend1;
        addr2 = addr1;
        pend1 = frb_read;
        addr1 = frb_address;
        #1;
        frb_readvalid = pend2;
        for (int i = 0; i < 16; i++) begin
            frb_readdata[32*i +: 32] = {6'(i), addr2, 16'(addr2 * 16'h9e37 + i)};
        end
    end

    task automatic add(input op_e op, input logic [15:0] addr, input logic [127:0] data,
                       input logic [15:0] be, input logic [127:0] exp);
        tbl.push_back('{op, addr, data, be, exp});
    endtask

    task automatic wait_read_valid();
        bit got;
        got = 0;
        for (int n = 0; n < 20 && !got; n++) begin
            @(posedge pcie_clk);
            if (pcie_readdatavalid) got = 1;
        end
        if (!got) begin
            $display("Timed out waiting for read data valid at %0t", $time);
            timeouts++;
        end
    endtask

    task automatic run_entry(input entry_t e);
        @(posedge pcie_clk);
        #1;
        pcie_address    = e.addr;
        pcie_writedata  = {384'b0, e.data};
        pcie_byteenable = {48'b0, e.be};
        table_exp       = e.exp;
        new_tail        = e.data[15:0];
        pcie_write      = (e.op == OP_WR);
        pcie_read       = (e.op == OP_RD || e.op == OP_BRD);
        dma_done        = (e.op == OP_DONE);
        @(posedge pcie_clk);
        #1;
        pcie_write = 1'b0;
        pcie_read  = 1'b0;
        dma_done   = 1'b0;
        if (e.op == OP_RD || e.op == OP_BRD) wait_read_valid();
    endtask

    initial begin
        bit up;
        pcie_read       = 1'b0;
        pcie_write      = 1'b0;
        dma_done        = 1'b0;
        new_tail        = '0;
        pcie_address    = '0;
        pcie_writedata  = '0;
        pcie_byteenable = '0;
        frb_readvalid   = 1'b0;
        frb_readdata    = '0;
        pend1           = 1'b0;
        pend2           = 1'b0;
        addr1           = '0;
        addr2           = '0;
        table_exp       = '0;
        total_core      = 3'd3;
        timeouts = 0;
        seed = 32'h89cf_ec23;
        up = 0;

        // reset state, then full and partial writes
        add(OP_RD, 16'h0000, '0, 16'h0, '0);
        add(OP_RD, 16'h1000, '0, 16'h0, '0);
        add(OP_RD, 16'h2000, '0, 16'h0, '0);
        add(OP_WR, 16'h0000, 128'h00000001_80001000_00000101_0000dead, 16'hffff, '0);
        add(OP_WR, 16'h1000, 128'h00000002_90002000_00000202_00000000, 16'hfff0, '0);
        add(OP_WR, 16'h2000, 128'h00000003_a0003000_00000303_00000000, 16'hfff0, '0);
        add(OP_WR, 16'h1000, 128'h11111111_22222222_00000999_00000000, 16'h0e70, '0);
        add(OP_WR, 16'h2000, 128'h00000000_00000000_ffff0404_00000000, 16'h00f0, '0);
        add(OP_RD, 16'h0000, '0, 16'h0, 128'h00000001_80001000_00000101_00000000);
        add(OP_RD, 16'h1000, '0, 16'h0, 128'h00000002_90002000_00000202_00000000);
        add(OP_RD, 16'h2000, '0, 16'h0, 128'h00000003_a0003000_00000404_00000000);
        add(OP_RD, 16'h3000, '0, 16'h0, '0);
        // tails through the core ring, wrapping at three
        add(OP_DONE, 16'h0, 128'h11, 16'h0, '0);
        add(OP_IDLE, 16'h0, '0, 16'h0, '0);
        add(OP_DONE, 16'h0, 128'h22, 16'h0, '0);
        add(OP_DONE, 16'h0, 128'h33, 16'h0, '0);
        add(OP_IDLE, 16'h0, '0, 16'h0, '0);
        add(OP_DONE, 16'h0, 128'h44, 16'h0, '0);
        add(OP_RD, 16'h0000, '0, 16'h0, 128'h00000001_80001000_00000101_00000044);
        add(OP_RD, 16'h1000, '0, 16'h0, 128'h00000002_90002000_00000202_00000022);
        add(OP_RD, 16'h2000, '0, 16'h0, 128'h00000003_a0003000_00000404_00000033);
        // ring buffer lines
        add(OP_BRD, 16'h4000, '0, 16'h0, '0);
        add(OP_BRD, 16'hffc0, '0, 16'h0, '0);
        for (int i = 0; i < 4; i++) begin
            add(OP_BRD, 16'((256 + $unsigned($random(seed)) % 768) * 64), '0, 16'h0, '0);
        end

        for (int n = 0; n < 10 && !up; n++) begin
            @(posedge pcie_clk);
            if (pcie_reset_n) up = 1;
        end
        if (!up) begin
            $display("Timed out waiting for reset release");
            timeouts++;
        end

        foreach (tbl[i]) begin
            run_entry(tbl[i]);
        end
        repeat (4) @(posedge pcie_clk);
        if (pending != 0) begin
            $display("Reads still outstanding at the end of the run: %0d", pending);
            timeouts++;
        end

        $display("errors: %0d mismatches, %0d assertion failures, %0d other failures",
                 error_count, dut.chk.assert_fails, timeouts);
        if (error_count == 0 && dut.chk.assert_fails == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none
`include "pcie_queue_cfg.svh"

module tb_scoreboard (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  logic                       pcie_read,
    input  logic                       pcie_write,
    input  pcie_queue_pkg::bar_addr_t  pcie_address,
    input  pcie_queue_pkg::bar_line_t  pcie_writedata,
    input  pcie_queue_pkg::bar_be_t    pcie_byteenable,
    input  pcie_queue_pkg::bar_line_t  pcie_readdata,
    input  logic                       pcie_readdatavalid,
    input  logic                       dma_done,
    input  pcie_queue_pkg::ring_ptr_t  new_tail,
    input  logic [2:0]                 total_core,
    input  logic                       frb_read,
    input  pcie_queue_pkg::line_addr_t frb_address,
    input  pcie_queue_pkg::bar_line_t  frb_readdata,
    input  logic                       frb_readvalid,
    input  pcie_queue_pkg::ring_ptr_t  f2c_head,
    input  pcie_queue_pkg::ring_ptr_t  f2c_tail,
    input  pcie_queue_pkg::kmem_addr_t f2c_kmem_addr,
    input  logic [127:0]               table_exp,
    output int                         error_count,
    output int                         pending
);

    pcie_queue_pkg::ring_ptr_t  m_tail [`PQ_NUM_CORES];
    pcie_queue_pkg::ring_ptr_t  m_head [`PQ_NUM_CORES];
    logic [31:0]                m_klo [`PQ_NUM_CORES];
    logic [31:0]                m_khi [`PQ_NUM_CORES];
    int                         m_core;
    pcie_queue_pkg::ring_ptr_t  e_head;
    pcie_queue_pkg::ring_ptr_t  e_tail;
    pcie_queue_pkg::kmem_addr_t e_kmem;
    bit                         armed;
    int                         line;
    int                         c;
    logic [127:0]               model_q [$];
    logic [127:0]               table_q [$];
    pcie_queue_pkg::bar_line_t  bram_q [$];
    bit                         region_q [$];

    initial begin
        error_count = 0;
        pending     = 0;
        armed       = 0;
    end

    // four dwords: tail, head, kmem low, kmem high
    function automatic logic [127:0] window(input int core);
        return {m_khi[core], m_klo[core], 16'h0, m_head[core], 16'h0, m_tail[core]};
    endfunction

    task automatic mismatch(input string name, input logic [511:0] exp, input logic [511:0] act);
        $display("Error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
        error_count++;
    endtask

    always @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int i = 0; i < `PQ_NUM_CORES; i++) begin
                m_tail[i] = '0;
                m_head[i] = '0;
                m_klo[i]  = '0;
                m_khi[i]  = '0;
            end
            m_core = 0;
            e_head = '0;
            e_tail = '0;
            e_kmem = '0;
            armed  = 1;
            model_q.delete();
            table_q.delete();
            bram_q.delete();
            region_q.delete();
        end else begin
            if (armed) begin
                if (f2c_head !== e_head) mismatch("f2c_head", e_head, f2c_head);
                if (f2c_tail !== e_tail) mismatch("f2c_tail", e_tail, f2c_tail);
                if (f2c_kmem_addr !== e_kmem) mismatch("f2c_kmem_addr", e_kmem, f2c_kmem_addr);
            end
            // selected queue registers the state before this edge
            e_head = m_head[m_core];
            e_tail = m_tail[m_core];
            e_kmem = {m_khi[m_core], m_klo[m_core]};

            if (pcie_readdatavalid) begin
                if (region_q.size() == 0) begin
                    $display("Read data valid arrived with no read outstanding at %0t", $time);
                    error_count++;
                end else if (region_q.pop_front()) begin
                    if (pcie_readdata !== {384'b0, model_q[0]})
                        mismatch("pcie_readdata", {384'b0, model_q[0]}, pcie_readdata);
                    if (pcie_readdata !== {384'b0, table_q[0]})
                        mismatch("pcie_readdata", {384'b0, table_q[0]}, pcie_readdata);
                    void'(model_q.pop_front());
                    void'(table_q.pop_front());
                end else if (bram_q.size() == 0) begin
                    $display("BRAM read answered before the BRAM port returned data");
                    error_count++;
                end else begin
                    if (pcie_readdata !== bram_q[0])
                        mismatch("pcie_readdata", bram_q[0], pcie_readdata);
                    void'(bram_q.pop_front());
                end
            end
            if (frb_readvalid) bram_q.push_back(frb_readdata);

            if (pcie_read) begin
                line = int'(pcie_address[15:6]);
                c    = int'(pcie_address[13:12]);
                if (line < `PQ_BRAM_OFFSET) begin
                    model_q.push_back(window(c));
                    table_q.push_back(table_exp);
                    region_q.push_back(1'b1);
                    if (frb_read !== 1'b0) mismatch("frb_read", 1'b0, frb_read);
                end else begin
                    region_q.push_back(1'b0);
                    if (frb_read !== 1'b1) mismatch("frb_read", 1'b1, frb_read);
                    if (frb_address !== 10'(line - `PQ_BRAM_OFFSET))
                        mismatch("frb_address", line - `PQ_BRAM_OFFSET, frb_address);
                end
            end else if (frb_read !== 1'b0) begin
                mismatch("frb_read", 1'b0, frb_read);
            end

            if (pcie_write && int'(pcie_address[15:6]) < `PQ_BRAM_OFFSET) begin
                c = int'(pcie_address[13:12]);
                if (pcie_byteenable[7:4] == 4'hf) m_head[c] = pcie_writedata[47:32];
                if (pcie_byteenable[11:8] == 4'hf) m_klo[c] = pcie_writedata[95:64];
                if (pcie_byteenable[15:12] == 4'hf) m_khi[c] = pcie_writedata[127:96];
            end
            if (dma_done) begin
                m_tail[m_core] = new_tail;
                m_core = (m_core == int'(total_core) - 1) ? 0 : m_core + 1;
            end
        end
        pending = region_q.size();
    end

endmodule

`default_nettype wire
